//--- files.f
rtl/ccnet_pkg.sv
rtl/ccnet_feeder.sv
rtl/ccnet_divider_stage.sv
rtl/ccnet_drain.sv
rtl/ccnet_top.sv
tb/ccnet_assert.sv
tb/tb_ccnet.sv

//--- tb/tb_ccnet.sv
`timescale 1ns/10ps
`default_nettype none

module tb_ccnet;

   localparam int N_RAND  = 2000;
   localparam int N_REQ   = 1 + 3 + 1 + 16 + ccnet_pkg::QDEPTH + N_RAND;
   localparam int MAX_CYC = 20 * N_REQ + 200;

   logic                    clk;
   logic                    rst_n;
   logic                    req_valid;
   ccnet_pkg::cc_req_t      req;
   wire                     req_ready;
   wire                     res_valid;
   logic                    res_ready;
   wire ccnet_pkg::cc_res_t res;
   ccnet_pkg::cc_res_t      exp_q [$];       // expected results, request order
   string                   test_name;
   int                      cyc = 0;
   int                      acc_cnt = 0;
   int                      chk_cnt = 0;
   logic                    rand_rdy;
   logic                    rdy_fixed;

   ccnet_top i_ccnet_top (
      .clk       (clk),
      .rst_n     (rst_n),
      .req_valid (req_valid),
      .req       (req),
      .req_ready (req_ready),
      .res_valid (res_valid),
      .res_ready (res_ready),
      .res       (res)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   ////////////////////////////////////////////////////////////////////////////
   // reference model
   function automatic ccnet_pkg::cc_res_t cc_model(input ccnet_pkg::cc_req_t rq);
      ccnet_pkg::cc_res_t o;
      logic               en [6];
      longint unsigned    er [6];
      longint unsigned    ev [6];
      longint unsigned    rp_r;
      longint unsigned    v;
      longint unsigned    r;
      case (rq.rp_sel)
         2'd0:    rp_r = 36000;
         2'd1:    rp_r = 12000;
         default: rp_r = 4700;
      endcase
      en = '{rq.partner_rd, rq.rp_en, rq.vconn_en, rq.io_low, rq.tx_en, 1'b1};
      er = '{ccnet_pkg::RD_OHM, rp_r, ccnet_pkg::VCONN_OHM, ccnet_pkg::IO_OHM,
             ccnet_pkg::BMC_OHM, ccnet_pkg::LEAK_OHM};
      ev = '{0, ccnet_pkg::RP_MV, ccnet_pkg::VCONN_MV, 0,
             rq.tx_dat ? ccnet_pkg::BMC_MV : 16'd0, 0};
      v = 0;
      r = 0;
      for (int i = 0; i < ccnet_pkg::N_DRV; i++) begin
         if (en[i]) begin
            if (r == 0) begin                    // open line
               v = ev[i];
               r = er[i];
            end else begin
               v = (ev[i] * r + v * er[i]) / (r + er[i]);
               r = (r * er[i]) / (r + er[i]);
            end
         end
      end
      o.v_cc       = ccnet_pkg::volt_t'(v);
      o.r_cc       = ccnet_pkg::ohm_t'(r);
      o.comp       = (v > ccnet_pkg::COMP_MV);
      o.sink_tx_ok = (v >= ccnet_pkg::SINK_OK_MV);
      o.sink_tx_ng = (v > ccnet_pkg::SINK_NG_MV) && (v < ccnet_pkg::SINK_OK_MV);
      return o;
   endfunction

   function automatic ccnet_pkg::cc_req_t rand_req();
      return ccnet_pkg::cc_req_t'(8'($urandom));
   endfunction

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("TEST FAIL");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic check_volt(input string name, input ccnet_pkg::volt_t want,
                             input ccnet_pkg::volt_t got);
      if (got !== want) begin
         fail_run($sformatf("Mismatch %s v_cc: expected %0d actual %0d", name, want, got));
      end
   endtask

   task automatic check_res(input string name, input ccnet_pkg::cc_res_t want,
                            input ccnet_pkg::cc_res_t got);
      if (got.r_cc !== want.r_cc || got.comp !== want.comp ||
          got.sink_tx_ok !== want.sink_tx_ok || got.sink_tx_ng !== want.sink_tx_ng) begin
         fail_run($sformatf("Mismatch %s r_cc/flags: expected %0d %b%b%b actual %0d %b%b%b",
                  name, want.r_cc, want.comp, want.sink_tx_ok, want.sink_tx_ng,
                  got.r_cc, got.comp, got.sink_tx_ok, got.sink_tx_ng));
      end
   endtask

   task automatic send_req(input ccnet_pkg::cc_req_t rq);
      @(negedge clk);
      req_valid = 1'b1;
      req       = rq;
      @(posedge clk);
      while (!req_ready) @(posedge clk);        // held until accepted
   endtask

   task automatic idle_req();
      @(negedge clk);
      req_valid = 1'b0;
   endtask

   task automatic drain_all();
      while (exp_q.size() != 0) @(negedge clk);
      repeat (2) @(negedge clk);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // monitors
   always @(posedge clk) begin
      if (rst_n && req_valid && req_ready) begin
         exp_q.push_back(cc_model(req));
         acc_cnt++;
      end
   end

   always @(posedge clk) begin
      ccnet_pkg::cc_res_t want;
      if (rst_n && res_valid && res_ready) begin
         if (exp_q.size() == 0) begin
            fail_run("result delivered with no request outstanding");
         end else begin
            want = exp_q.pop_front();
            check_volt(test_name, want.v_cc, res.v_cc);
            check_res(test_name, want, res);
            chk_cnt++;
         end
      end
   end

   always @(posedge clk) begin
      cyc++;
      if (cyc > MAX_CYC) begin
         fail_run($sformatf("timeout, run still going after %0d cycles", MAX_CYC));
      end
   end

   always @(negedge clk) begin
      res_ready = rand_rdy ? (($urandom % 4) != 0) : rdy_fixed;
   end

   ////////////////////////////////////////////////////////////////////////////
   // stimulus
   initial begin
      ccnet_pkg::cc_req_t rq;
      int                 lat;
      int                 acc0;
      void'($urandom(32'h017fde3b));
      rst_n     = 1'b0;
      req_valid = 1'b0;
      req       = '0;
      res_ready = 1'b0;
      rand_rdy  = 1'b0;
      rdy_fixed = 1'b1;
      test_name = "reset";
      repeat (4) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      test_name = "rd only";
      @(negedge clk);
      if (req_ready !== 1'b1 || res_valid !== 1'b0) begin
         fail_run("req_ready or res_valid wrong after reset");
      end
      rq            = '0;
      rq.partner_rd = 1'b1;
      send_req(rq);
      idle_req();
      drain_all();

      test_name = "rp with rd";
      for (int s = 0; s < 3; s++) begin
         rq            = '0;
         rq.rp_en      = 1'b1;
         rq.rp_sel     = ccnet_pkg::rp_sel_t'(s);
         rq.partner_rd = 1'b1;
         send_req(rq);
      end
      idle_req();
      drain_all();

      test_name = "latency";
      rq            = '0;
      rq.rp_en      = 1'b1;
      rq.partner_rd = 1'b1;
      send_req(rq);
      lat = 0;
      do begin
         @(negedge clk);
         req_valid = 1'b0;
         lat++;
      end while (res_valid !== 1'b1);
      if (lat != ccnet_pkg::N_DRV + 2) begin
         fail_run($sformatf("Mismatch latency: expected %0d actual %0d",
                  ccnet_pkg::N_DRV + 2, lat));
      end
      drain_all();

      test_name = "bmc vconn io";
      for (int k = 0; k < 16; k++) begin
         rq            = '0;
         rq.tx_en      = 1'b1;
         rq.tx_dat     = k[0];
         rq.vconn_en   = k[1];
         rq.io_low     = k[2];
         rq.rp_en      = k[3];
         rq.rp_sel     = 2'd2;
         rq.partner_rd = 1'b1;
         send_req(rq);
      end
      idle_req();
      drain_all();

      test_name = "back pressure";
      rdy_fixed = 1'b0;
      repeat (2) @(negedge clk);
      acc0 = acc_cnt;
      repeat (20) begin
         @(negedge clk);
         req_valid = 1'b1;
         req       = rand_req();
      end
      @(negedge clk);
      req_valid = 1'b0;
      if (acc_cnt - acc0 != ccnet_pkg::QDEPTH) begin
         fail_run($sformatf("Mismatch back pressure accepts: expected %0d actual %0d",
                  ccnet_pkg::QDEPTH, acc_cnt - acc0));
      end
      if (req_ready !== 1'b0) begin
         fail_run("req_ready still high with all credits spent");
      end
      rdy_fixed = 1'b1;
      drain_all();

      test_name = "random";
      rand_rdy = 1'b1;
      repeat (N_RAND) send_req(rand_req());
      idle_req();
      rand_rdy = 1'b0;
      drain_all();

      if (chk_cnt == N_REQ) begin
         $display("TEST PASS");
         $finish;
      end else begin
         fail_run($sformatf("%0d requests sent but %0d results checked", N_REQ, chk_cnt));
      end
   end

endmodule

`default_nettype wire

//--- tb/ccnet_assert.sv
`timescale 1ns/10ps
`default_nettype none

module ccnet_assert (
   input wire                     clk,
   input wire                     rst_n,
   input wire                     req_ready,
   input wire                     res_valid,
   input wire                     res_ready,
   input wire ccnet_pkg::cc_res_t res,
   input wire                     credit_ret,
   input wire ccnet_pkg::credit_t credit_cnt,
   input wire ccnet_pkg::credit_t q_count,
   input wire ccnet_pkg::pipe_t   pipe_chain [0:ccnet_pkg::N_DRV]
);

   int in_flight;                                // accepted, credit not yet back

   always_comb begin
      in_flight = int'(q_count) + int'(credit_ret);
      for (int k = 0; k <= ccnet_pkg::N_DRV; k++) begin
         in_flight += int'(pipe_chain[k].valid);
      end
   end

   a_ready_needs_credit: assert property (@(posedge clk) disable iff (!rst_n)
      (in_flight >= ccnet_pkg::QDEPTH) |-> !req_ready)   // whole budget in flight
      else $error("req_ready high with the whole credit budget in flight");

   a_res_held: assert property (@(posedge clk) disable iff (!rst_n)
      (res_valid && !res_ready) |=> (res_valid && $stable(res)))   // head held while stalled
      else $error("res changed while stalled");

   a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
      credit_ret |=> (credit_cnt <= ccnet_pkg::QDEPTH))
      else $error("credit count above queue depth");

   a_reset_quiet: assert property (@(posedge clk)
      $rose(rst_n) |-> !res_valid)
      else $error("res_valid high right after reset");

endmodule

bind ccnet_top ccnet_assert i_ccnet_assert (
   .clk        (clk),
   .rst_n      (rst_n),
   .req_ready  (req_ready),
   .res_valid  (res_valid),
   .res_ready  (res_ready),
   .res        (res),
   .credit_ret (credit_ret),
   .credit_cnt (i_feeder.credit_cnt),
   .q_count    (i_drain.count),
   .pipe_chain (pipe_chain)
);

`default_nettype wire

//--- rtl/ccnet_top.sv
`timescale 1ns/10ps
`default_nettype none

module ccnet_top (
   input  wire                     clk,
   input  wire                     rst_n,
   input  wire                     req_valid,
   input  wire ccnet_pkg::cc_req_t req,
   output wire                     req_ready,
   output wire                     res_valid,
   input  wire                     res_ready,
   output wire ccnet_pkg::cc_res_t res
);

   ccnet_pkg::pipe_t pipe_chain [0:ccnet_pkg::N_DRV];   // feeder, then one per stage
   logic             credit_ret;

   ////////////////////////////////////////////////////////////////////////////
   // request side
   ccnet_feeder i_feeder (
      .clk        (clk),
      .rst_n      (rst_n),
      .req_valid  (req_valid),
      .req        (req),
      .req_ready  (req_ready),
      .credit_ret (credit_ret),
      .pipe_out   (pipe_chain[0])
   );

   ////////////////////////////////////////////////////////////////////////////
   // divider chain, entry i folded in stage i
   for (genvar i = 0; i < ccnet_pkg::N_DRV; i++) begin : g_stage
      ccnet_divider_stage #(
         .STAGE (i)
      ) i_stage (
         .clk      (clk),
         .rst_n    (rst_n),
         .pipe_in  (pipe_chain[i]),
         .pipe_out (pipe_chain[i+1])
      );
   end

   ////////////////////////////////////////////////////////////////////////////
   // result side
   ccnet_drain i_drain (
      .clk        (clk),
      .rst_n      (rst_n),
      .pipe_in    (pipe_chain[ccnet_pkg::N_DRV]),
      .res_valid  (res_valid),
      .res_ready  (res_ready),
      .res        (res),
      .credit_ret (credit_ret)
   );

endmodule

`default_nettype wire

//--- rtl/ccnet_drain.sv
`timescale 1ns/10ps
`default_nettype none

module ccnet_drain (
   input  wire                   clk,
   input  wire                   rst_n,
   input  wire ccnet_pkg::pipe_t pipe_in,
   output logic                  res_valid,
   input  wire                   res_ready,
   output ccnet_pkg::cc_res_t    res,
   output logic                  credit_ret
);

   ccnet_pkg::cc_res_t res_d;
   ccnet_pkg::cc_res_t mem [ccnet_pkg::QDEPTH];
   ccnet_pkg::qptr_t   wr_ptr;
   ccnet_pkg::qptr_t   rd_ptr;
   ccnet_pkg::credit_t count;
   ccnet_pkg::volt_t   v_fin;
   logic               push;
   logic               pop;

   ////////////////////////////////////////////////////////////////////////////
   // comparator and sink tx decode
   assign v_fin = pipe_in.net.v;

   always_comb begin
      res_d.v_cc       = v_fin;
      res_d.r_cc       = pipe_in.net.r;
      res_d.comp       = (v_fin > ccnet_pkg::COMP_MV);
      res_d.sink_tx_ok = (v_fin >= ccnet_pkg::SINK_OK_MV);
      res_d.sink_tx_ng = (v_fin > ccnet_pkg::SINK_NG_MV) &&
                         (v_fin < ccnet_pkg::SINK_OK_MV);
   end

   ////////////////////////////////////////////////////////////////////////////
   // result queue
   assign push      = pipe_in.valid;             // credits keep it from overflow
   assign res_valid = (count != '0);
   assign pop       = res_valid & res_ready;
   assign res       = mem[rd_ptr];               // head stays put until popped

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= res_d;
      end
   end

   // pointers wrap on their own, QDEPTH is a power of two
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         count <= '0;
      end else if (push != pop) begin
         if (push) begin
            count <= count + 1'b1;
         end else begin
            count <= count - 1'b1;
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // credit return, one pulse per pop
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         credit_ret <= 1'b0;
      end else begin
         credit_ret <= pop;
      end
   end

endmodule

`default_nettype wire

//--- rtl/ccnet_divider_stage.sv
`timescale 1ns/10ps
`default_nettype none

module ccnet_divider_stage #(
   parameter int STAGE = 0
) (
   input  wire                   clk,
   input  wire                   rst_n,
   input  wire ccnet_pkg::pipe_t pipe_in,
   output ccnet_pkg::pipe_t      pipe_out
);

   ccnet_pkg::drv_t                         ent;
   ccnet_pkg::net_t                         net_in;
   ccnet_pkg::net_t                         net_d;
   ccnet_pkg::net_t                         net_q;
   ccnet_pkg::drv_t [ccnet_pkg::N_DRV-1:0] drv_q;
   logic                                    vld_q;
   logic [24:0]                             den;
   logic [40:0]                             num_v;
   logic [47:0]                             num_r;
   logic [40:0]                             quo_v;
   logic [47:0]                             quo_r;

   assign ent    = pipe_in.drv[STAGE];
   assign net_in = pipe_in.net;

   // thevenin fold of running network with this entry
   assign den   = {1'b0, net_in.r} + {1'b0, ent.r};
   assign num_v = 41'(ent.v) * 41'(net_in.r) + 41'(net_in.v) * 41'(ent.r);
   assign num_r = 48'(net_in.r) * 48'(ent.r);
   assign quo_v = num_v / 41'(den);              // truncating
   assign quo_r = num_r / 48'(den);

   always_comb begin
      net_d = net_in;
      if (ent.en) begin
         if (net_in.r == '0) begin               // open, entry takes over
            net_d.v = ent.v;
            net_d.r = ent.r;
         end else begin
            net_d.v = quo_v[15:0];               // weighted mean fits 16 bits
            net_d.r = quo_r[23:0];               // parallel below either r
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         vld_q <= 1'b0;
      end else begin
         vld_q <= pipe_in.valid;
      end
   end

   always_ff @(posedge clk) begin
      if (pipe_in.valid) begin
         drv_q <= pipe_in.drv;
         net_q <= net_d;
      end
   end

   assign pipe_out = '{valid: vld_q, drv: drv_q, net: net_q};

endmodule

`default_nettype wire

//--- rtl/ccnet_feeder.sv
`timescale 1ns/10ps
`default_nettype none

module ccnet_feeder (
   input  wire                     clk,
   input  wire                     rst_n,
   input  wire                     req_valid,
   input  wire ccnet_pkg::cc_req_t req,
   output logic                    req_ready,
   input  wire                     credit_ret,
   output ccnet_pkg::pipe_t        pipe_out
);

   ccnet_pkg::drv_t [ccnet_pkg::N_DRV-1:0] tab_d;
   ccnet_pkg::drv_t [ccnet_pkg::N_DRV-1:0] tab_q;
   ccnet_pkg::ohm_t                         rp_ohm;
   ccnet_pkg::credit_t                      credit_cnt;
   logic                                    vld_q;
   logic                                    accept;

   assign req_ready = (credit_cnt != '0);        // one free queue slot per credit
   assign accept    = req_valid & req_ready;

   ////////////////////////////////////////////////////////////////////////////
   // driver table decode
   always_comb begin
      case (req.rp_sel)
         2'd0:    rp_ohm = ccnet_pkg::RP_DEF_OHM;
         2'd1:    rp_ohm = ccnet_pkg::RP_1A5_OHM;
         default: rp_ohm = ccnet_pkg::RP_3A0_OHM;
      endcase
   end

   always_comb begin
      tab_d[0] = '{en: req.partner_rd, r: ccnet_pkg::RD_OHM, v: '0};
      tab_d[1] = '{en: req.rp_en, r: rp_ohm, v: ccnet_pkg::RP_MV};
      tab_d[2] = '{en: req.vconn_en, r: ccnet_pkg::VCONN_OHM, v: ccnet_pkg::VCONN_MV};
      tab_d[3] = '{en: req.io_low, r: ccnet_pkg::IO_OHM, v: '0};
      tab_d[4].en = req.tx_en;                   // bmc driver
      tab_d[4].r  = ccnet_pkg::BMC_OHM;
      tab_d[4].v  = req.tx_dat ? ccnet_pkg::BMC_MV : ccnet_pkg::volt_t'(0);
      tab_d[5] = '{en: 1'b1, r: ccnet_pkg::LEAK_OHM, v: '0};
   end

   ////////////////////////////////////////////////////////////////////////////
   // stage 0 register
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         vld_q <= 1'b0;
      end else begin
         vld_q <= accept;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         tab_q <= tab_d;
      end
   end

   assign pipe_out = '{valid: vld_q, drv: tab_q, net: '0};   // network starts open

   ////////////////////////////////////////////////////////////////////////////
   // credits
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         credit_cnt <= ccnet_pkg::credit_t'(ccnet_pkg::QDEPTH);
      end else if (accept != credit_ret) begin   // both at once cancel out
         if (accept) begin
            credit_cnt <= credit_cnt - 1'b1;
         end else begin
            credit_cnt <= credit_cnt + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

//--- rtl/ccnet_pkg.sv
`default_nettype none

package ccnet_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // sizes
   localparam int N_DRV    = 6;                  // drivers, also stage count
   localparam int QDEPTH   = 4;                  // drain queue, initial credits
   localparam int CREDIT_W = 3;
   localparam int QPTR_W   = $clog2(QDEPTH);

   typedef logic [15:0]         volt_t;          // mV
   typedef logic [23:0]         ohm_t;           // ohm, 0 is open
   typedef logic [1:0]          rp_sel_t;
   typedef logic [CREDIT_W-1:0] credit_t;
   typedef logic [QPTR_W-1:0]   qptr_t;

   ////////////////////////////////////////////////////////////////////////////
   // thresholds and driver constants
   localparam volt_t COMP_MV    = 16'd550;
   localparam volt_t SINK_OK_MV = 16'd1000;
   localparam volt_t SINK_NG_MV = 16'd400;

   localparam ohm_t  RD_OHM     = 24'd5_100;     // partner pull-down
   localparam ohm_t  VCONN_OHM  = 24'd10;        // 50mA at 0.5V drop
   localparam volt_t VCONN_MV   = 16'd5000;
   localparam ohm_t  IO_OHM     = 24'd200;       // open-drain VOL
   localparam ohm_t  BMC_OHM    = 24'd350;
   localparam volt_t BMC_MV     = 16'd1125;
   localparam ohm_t  LEAK_OHM   = 24'd900_000;
   localparam volt_t RP_MV      = 16'd3300;
   localparam ohm_t  RP_DEF_OHM = 24'd36_000;    // default usb power
   localparam ohm_t  RP_1A5_OHM = 24'd12_000;
   localparam ohm_t  RP_3A0_OHM = 24'd4_700;

   ////////////////////////////////////////////////////////////////////////////
   // bundles
   typedef struct packed {
      logic    rp_en;
      rp_sel_t rp_sel;
      logic    vconn_en;
      logic    io_low;
      logic    tx_en;
      logic    tx_dat;
      logic    partner_rd;
   } cc_req_t;

   typedef struct packed {
      logic  en;
      ohm_t  r;
      volt_t v;
   } drv_t;

   typedef struct packed {
      volt_t v;
      ohm_t  r;
   } net_t;

   typedef struct packed {
      logic                   valid;
      drv_t [N_DRV-1:0]       drv;
      net_t                   net;
   } pipe_t;

   typedef struct packed {
      volt_t v_cc;
      ohm_t  r_cc;
      logic  comp;
      logic  sink_tx_ok;
      logic  sink_tx_ng;
   } cc_res_t;

endpackage

`default_nettype wire
